// ==== common/pwconv_pkg.sv ====
package pwconv_pkg;

    localparam int IN_CHANNELS = 3;
    localparam int OUT_CHANNELS = 4;

    // One advance cycle per output channel, because a single chain is time-shared.
    localparam int PHASES = OUT_CHANNELS;

    localparam int ACT_WIDTH = 8;
    localparam int WEIGHT_WIDTH = 8;

    // Full product plus headroom for IN_CHANNELS accumulations.
    localparam int SUM_WIDTH = ACT_WIDTH + WEIGHT_WIDTH + $clog2(IN_CHANNELS);

    // Each stage adds one register, so the last phase leaves the chain this many cycles later.
    localparam int PIPE_DEPTH = IN_CHANNELS;

    typedef logic [ACT_WIDTH-1:0] act_t;
    typedef logic [WEIGHT_WIDTH-1:0] weight_t;
    typedef logic [SUM_WIDTH-1:0] sum_t;
    typedef logic [$clog2(PHASES)-1:0] phase_t;
    typedef act_t [IN_CHANNELS-1:0] in_vec_t;
    typedef act_t [OUT_CHANNELS-1:0] out_vec_t;

    // Row j holds the weights of output channel j, column i those of input channel i.
    localparam weight_t WEIGHTS [OUT_CHANNELS][IN_CHANNELS] = '{
        '{8'd3, 8'd250, 8'd17},
        '{8'd128, 8'd1, 8'd64},
        '{8'd255, 8'd7, 8'd200},
        '{8'd12, 8'd99, 8'd0}
    };

    // Steps a phase counter and wraps after the last phase.
    function automatic phase_t next_phase(phase_t phase);
        if (phase == phase_t'(PHASES - 1)) begin
            return '0;
        end
        return phase + 1'b1;
    endfunction : next_phase

endpackage : pwconv_pkg

// ==== common/pwconv_ctrl_if.sv ====
`timescale 1ns/1ps

interface pwconv_ctrl_if;
    import pwconv_pkg::*;

    // Global enable for every register in the datapath.
    logic advance;
    logic in_valid;
    logic out_valid;
    phase_t out_phase;

    modport ctrl (
        output advance, in_valid, out_valid, out_phase
    );

    modport chain (
        input advance, in_valid
    );

    modport gather (
        input advance, out_valid, out_phase
    );

endinterface : pwconv_ctrl_if

// ==== mac_chain/mac_stage.sv ====
`timescale 1ns/1ps

module mac_stage #(
    parameter int STAGE = 0
) (
    input  logic             clock_i,
    input  logic             reset_i,
    pwconv_ctrl_if.chain     ctrl,
    input  pwconv_pkg::act_t act_i,
    input  pwconv_pkg::sum_t sum_i,
    output pwconv_pkg::sum_t sum_o
);
    import pwconv_pkg::*;

    act_t act_skewed;
    logic valid_skewed;
    phase_t phase;
    weight_t weight;
    sum_t product;

    // The activation is delayed by STAGE cycles so that it meets the partial sum
    // coming down the chain.
    if (STAGE == 0) begin : g_no_skew
        assign act_skewed = act_i;
        assign valid_skewed = ctrl.in_valid;
    end : g_no_skew
    else begin : g_skew
        act_t act_q [STAGE];
        logic [STAGE-1:0] valid_q;

        always_ff @(posedge clock_i) begin
            if (ctrl.advance) begin
                act_q[0] <= act_i;
                for (int i = 1; i < STAGE; i++) begin
                    act_q[i] <= act_q[i-1];
                end
            end
        end

        always_ff @(posedge clock_i) begin
            if (!reset_i) begin
                valid_q <= '0;
            end else if (ctrl.advance) begin
                valid_q[0] <= ctrl.in_valid;
                for (int i = 1; i < STAGE; i++) begin
                    valid_q[i] <= valid_q[i-1];
                end
            end
        end

        assign act_skewed = act_q[STAGE-1];
        assign valid_skewed = valid_q[STAGE-1];
    end : g_skew

    // Each stage tracks its own phase, since it sees the element STAGE cycles late.
    always_ff @(posedge clock_i) begin
        if (!reset_i) begin
            phase <= '0;
        end else if (ctrl.advance && valid_skewed) begin
            phase <= next_phase(phase);
        end
    end

    assign weight = WEIGHTS[phase][STAGE];
    assign product = sum_t'(weight) * sum_t'(act_skewed);

    always_ff @(posedge clock_i) begin
        if (ctrl.advance) begin
            sum_o <= sum_i + product;
        end
    end

    // A gap in the valid stream falls only between elements, when the phase is back at zero.
    idle_phase_a: assert property (
        @(posedge clock_i) disable iff (!reset_i)
        ctrl.advance && !valid_skewed |-> phase == '0
    );

endmodule : mac_stage

// ==== mac_chain/mac_chain.sv ====
`timescale 1ns/1ps

module mac_chain (
    input  logic                clock_i,
    input  logic                reset_i,
    pwconv_ctrl_if.chain        ctrl,
    input  pwconv_pkg::in_vec_t data_i,
    output pwconv_pkg::act_t    result_o
);
    import pwconv_pkg::*;

    // Entry k is the partial sum entering stage k, the last one leaves the chain.
    sum_t sums [IN_CHANNELS+1];

    assign sums[0] = '0;

    for (genvar k = 0; k < IN_CHANNELS; k++) begin : g_stage
        mac_stage #(
            .STAGE(k)
        ) mac_stage_inst (
            .clock_i(clock_i),
            .reset_i(reset_i),
            .ctrl   (ctrl),
            .act_i  (data_i[k]),
            .sum_i  (sums[k]),
            .sum_o  (sums[k+1])
        );
    end : g_stage

    // Only the low bits are kept, which are the same for signed and unsigned operands.
    assign result_o = sums[IN_CHANNELS][ACT_WIDTH-1:0];

endmodule : mac_chain

// ==== design/stream_control.sv ====
`timescale 1ns/1ps

module stream_control (
    input  logic clock_i,
    input  logic reset_i,
    input  logic slave_valid_i,
    input  logic master_ready_i,
    output logic slave_ready_o,
    output logic master_valid_o,
    pwconv_ctrl_if.ctrl ctrl
);
    import pwconv_pkg::*;

    phase_t in_phase;
    phase_t out_phase;
    logic [PIPE_DEPTH-1:0] valid_pipe;

    // Back-pressure from downstream stalls the whole pipeline.
    assign ctrl.advance = master_ready_i;
    assign ctrl.in_valid = slave_valid_i && master_ready_i;
    assign ctrl.out_valid = valid_pipe[PIPE_DEPTH-1];
    assign ctrl.out_phase = out_phase;

    // The element is held upstream until every phase has entered the chain.
    always_ff @(posedge clock_i) begin
        if (!reset_i) begin
            in_phase <= '0;
        end else if (ctrl.in_valid) begin
            in_phase <= next_phase(in_phase);
        end
    end

    assign slave_ready_o = master_ready_i && (in_phase == phase_t'(PHASES - 1));

    // Valid follows the data through the chain, one bit per stage register.
    always_ff @(posedge clock_i) begin
        if (!reset_i) begin
            valid_pipe <= '0;
        end else if (ctrl.advance) begin
            valid_pipe[0] <= ctrl.in_valid;
            for (int i = 1; i < PIPE_DEPTH; i++) begin
                valid_pipe[i] <= valid_pipe[i-1];
            end
        end
    end

    always_ff @(posedge clock_i) begin
        if (!reset_i) begin
            out_phase <= '0;
        end else if (ctrl.advance && ctrl.out_valid) begin
            out_phase <= next_phase(out_phase);
        end
    end

    // The whole element is complete once its last channel leaves the chain.
    assign master_valid_o = ctrl.out_valid && (out_phase == phase_t'(PHASES - 1));

    // Every valid bit in the delay line is an entered phase that has not yet left the chain.
    phase_balance_a: assert property (
        @(posedge clock_i) disable iff (!reset_i)
        phase_t'(in_phase - out_phase) == phase_t'($countones(valid_pipe))
    );

    // A reset edge clears both counters and the delay line before the next sample.
    quiet_in_reset_a: assert property (
        @(posedge clock_i)
        !reset_i |=> !master_valid_o && !slave_ready_o
    );

endmodule : stream_control

// ==== design/output_gather.sv ====
`timescale 1ns/1ps

module output_gather (
    input  logic                 clock_i,
    pwconv_ctrl_if.gather        ctrl,
    input  pwconv_pkg::act_t     result_i,
    output pwconv_pkg::out_vec_t data_o
);
    import pwconv_pkg::*;

    // Output channel ch is computed in phase ch.
    for (genvar ch = 0; ch < PHASES; ch++) begin : g_channel
        if (ch == PHASES - 1) begin : g_last
            // The last channel is on the chain output when the element is presented.
            assign data_o[ch] = result_i;
        end : g_last
        else begin : g_buffered
            act_t buffer;

            always_ff @(posedge clock_i) begin
                if (ctrl.advance && ctrl.out_valid && ctrl.out_phase == phase_t'(ch)) begin
                    buffer <= result_i;
                end
            end

            assign data_o[ch] = buffer;
        end : g_buffered
    end : g_channel

endmodule : output_gather

// ==== design/pwconv_top.sv ====
`timescale 1ns/1ps

module pwconv_top (
    input  logic                 clock_i,
    input  logic                 reset_i,

    input  logic                 slave_valid_i,
    output logic                 slave_ready_o,
    input  pwconv_pkg::in_vec_t  slave_data_i,

    output logic                 master_valid_o,
    input  logic                 master_ready_i,
    output pwconv_pkg::out_vec_t master_data_o
);
    import pwconv_pkg::*;

    // Low bits of the chain output for the phase that is leaving the chain.
    act_t result;

    pwconv_ctrl_if ctrl_if ();

    stream_control stream_control_inst (
        .clock_i       (clock_i),
        .reset_i       (reset_i),
        .slave_valid_i (slave_valid_i),
        .master_ready_i(master_ready_i),
        .slave_ready_o (slave_ready_o),
        .master_valid_o(master_valid_o),
        .ctrl          (ctrl_if.ctrl)
    );

    mac_chain mac_chain_inst (
        .clock_i (clock_i),
        .reset_i (reset_i),
        .ctrl    (ctrl_if.chain),
        .data_i  (slave_data_i),
        .result_o(result)
    );

    output_gather output_gather_inst (
        .clock_i (clock_i),
        .ctrl    (ctrl_if.gather),
        .result_i(result),
        .data_o  (master_data_o)
    );

endmodule : pwconv_top

// ==== dv/pwconv_tb.sv ====
`timescale 1ns/1ps

module pwconv_tb;
    import pwconv_pkg::*;

    localparam int MAX_ROWS = 24;
    localparam int RESET_CYCLES = 5;
    localparam int WAIT_LIMIT = 64;
    // Stalls start after two advance cycles of an element, when the previous one is presented.
    localparam int STALL_AT = 2;

    logic clock_i = 1'b0;
    logic reset_i;
    logic slave_valid_i;
    logic slave_ready_o;
    in_vec_t slave_data_i;
    logic master_valid_o;
    logic master_ready_i;
    out_vec_t master_data_o;

    // Stimulus table, one row per element, with the expected output element.
    int row_test [MAX_ROWS];
    in_vec_t row_act [MAX_ROWS];
    int row_idle [MAX_ROWS];
    int row_stall [MAX_ROWS];
    out_vec_t row_exp [MAX_ROWS];
    int n_rows = 0;

    integer seed;
    int cur_row = 0;
    bit timed_out = 1'b0;
    int checks = 0;
    int errors = 0;
    int error_mark = 0;
    int mon_checks = 0;
    int mon_errors = 0;
    int handshakes = 0;
    int outputs = 0;
    int adv_count = 0;
    out_vec_t exp_q [$];
    int hs_q [$];

    pwconv_top pwconv_top_inst (
        .clock_i       (clock_i),
        .reset_i       (reset_i),
        .slave_valid_i (slave_valid_i),
        .slave_ready_o (slave_ready_o),
        .slave_data_i  (slave_data_i),
        .master_valid_o(master_valid_o),
        .master_ready_i(master_ready_i),
        .master_data_o (master_data_o)
    );

    always #5 clock_i = ~clock_i;

    // Output channel j is the weighted sum of the inputs, wrapped to ACT_WIDTH bits.
    function automatic out_vec_t model(input in_vec_t x);
        out_vec_t y;
        int acc;
        for (int j = 0; j < OUT_CHANNELS; j++) begin
            acc = 0;
            for (int i = 0; i < IN_CHANNELS; i++) begin
                acc += int'(WEIGHTS[j][i]) * int'(x[i]);
            end
            y[j] = act_t'(acc % 256);
        end
        return y;
    endfunction

    function automatic string test_title(input int t);
        case (t)
            1: return "reset";
            2: return "single element";
            3: return "streaming";
            4: return "back-pressure";
            default: return "bubbles";
        endcase
    endfunction

    task automatic verify(input bit cond, input string what);
        checks++;
        assert (cond) else begin
            $display("CHECK FAILED at %0t: %s", $time, what);
            errors++;
        end
    endtask

    task automatic add_row(input int test, input in_vec_t act, input int idle, input int stall);
        row_test[n_rows] = test;
        row_act[n_rows] = act;
        row_idle[n_rows] = idle;
        row_stall[n_rows] = stall;
        row_exp[n_rows] = model(act);
        n_rows++;
    endtask

    task automatic build_table();
        in_vec_t act;
        int gap;
        // All ones and all zeros make every channel wrap or stay at zero.
        add_row(2, '1, 6, 0);
        add_row(2, '0, 6, 0);
        act = in_vec_t'($random(seed));
        add_row(2, act, 6, 0);
        for (int r = 0; r < 5; r++) begin
            act = in_vec_t'($random(seed));
            add_row(3, act, 0, 0);
        end
        for (int r = 0; r < 4; r++) begin
            act = in_vec_t'($random(seed));
            add_row(4, act, 0, 1 + 2 * (r % 3));
        end
        for (int r = 0; r < 6; r++) begin
            act = in_vec_t'($random(seed));
            gap = int'($unsigned($random(seed)) % 6);
            add_row(5, act, gap, 0);
        end
    endtask

    task automatic hold_back(input int len);
        logic held_valid;
        out_vec_t held_data;
        @(negedge clock_i);
        held_valid = master_valid_o;
        held_data = master_data_o;
        master_ready_i = 1'b0;
        repeat (len) begin
            @(posedge clock_i);
            verify(!slave_ready_o, "slave_ready_o high while master_ready_i is low");
            verify(master_valid_o === held_valid && master_data_o === held_data,
                   "master outputs changed while master_ready_i is low");
            @(negedge clock_i);
        end
        master_ready_i = 1'b1;
    endtask

    task automatic drive_element(input int idx);
        int cycles;
        int waited;
        bit done;
        cycles = 0;
        waited = 0;
        done = 1'b0;
        repeat (row_idle[idx]) begin
            @(negedge clock_i);
            slave_valid_i = 1'b0;
        end
        @(negedge clock_i);
        cur_row = idx;
        slave_valid_i = 1'b1;
        slave_data_i = row_act[idx];
        while (!done && waited < WAIT_LIMIT) begin
            @(posedge clock_i);
            waited++;
            if (slave_ready_o) begin
                done = 1'b1;
            end else begin
                cycles++;
                if (cycles == STALL_AT && row_stall[idx] > 0) begin
                    hold_back(row_stall[idx]);
                end else begin
                    @(negedge clock_i);
                end
            end
        end
        if (done) begin
            verify(cycles + 1 == PHASES, $sformatf("element %0d accepted after %0d cycles",
                                                   idx, cycles + 1));
        end else begin
            $display("Timed out waiting for slave_ready_o on element %0d", idx);
            timed_out = 1'b1;
        end
    endtask

    task automatic drain_outputs();
        int waited;
        waited = 0;
        @(negedge clock_i);
        slave_valid_i = 1'b0;
        while (exp_q.size() > 0 && waited < WAIT_LIMIT) begin
            @(posedge clock_i);
            waited++;
        end
        if (exp_q.size() > 0) begin
            $display("Timed out waiting for %0d results to leave the pipeline", exp_q.size());
            timed_out = 1'b1;
        end
    endtask

    task automatic report_test(input int t);
        int now_errors;
        now_errors = errors + mon_errors;
        $display("Test %0d (%s): %0d errors", t, test_title(t), now_errors - error_mark);
        error_mark = now_errors;
    endtask

    // Scoreboard. The latency is counted in advance cycles only.
    always @(posedge clock_i) begin
        if (reset_i && master_ready_i) begin
            if (master_valid_o) begin
                outputs++;
                mon_checks++;
                assert (exp_q.size() > 0) else begin
                    $display("An output element appeared at %0t with none pending", $time);
                    mon_errors++;
                end
                if (exp_q.size() > 0) begin
                    mon_checks += 2;
                    assert (master_data_o == exp_q[0]) else begin
                        $display("CHECK FAILED at %0t: master_data_o is %h, expected %h",
                                 $time, master_data_o, exp_q[0]);
                        mon_errors++;
                    end
                    assert (adv_count - hs_q[0] == PIPE_DEPTH) else begin
                        $display("CHECK FAILED at %0t: latency %0d, expected %0d",
                                 $time, adv_count - hs_q[0], PIPE_DEPTH);
                        mon_errors++;
                    end
                    exp_q.delete(0);
                    hs_q.delete(0);
                end
            end
            if (slave_valid_i && slave_ready_o) begin
                handshakes++;
                exp_q.push_back(row_exp[cur_row]);
                hs_q.push_back(adv_count);
            end
            adv_count++;
        end
    end

    initial begin
        reset_i = 1'b0;
        slave_valid_i = 1'b1;
        master_ready_i = 1'b1;
        slave_data_i = '0;
        seed = 79;
        build_table();

        for (int c = 0; c < RESET_CYCLES; c++) begin
            @(posedge clock_i);
            // The first edge applies the reset, so the outputs are known from the second on.
            if (c > 0) begin
                verify(!slave_ready_o && !master_valid_o, "ready or valid high during reset");
            end
        end
        @(negedge clock_i);
        reset_i = 1'b1;
        slave_valid_i = 1'b0;
        @(posedge clock_i);
        verify(!slave_ready_o && !master_valid_o, "ready or valid high just after reset");
        report_test(1);

        for (int idx = 0; idx < n_rows && !timed_out; idx++) begin
            drive_element(idx);
            if (!timed_out && (idx == n_rows - 1 || row_test[idx + 1] != row_test[idx])) begin
                drain_outputs();
                verify(handshakes == outputs,
                       $sformatf("%0d handshakes but %0d outputs", handshakes, outputs));
                report_test(row_test[idx]);
            end
        end

        $display("Checks: %0d, errors: %0d, handshakes: %0d, outputs: %0d",
                 checks + mon_checks, errors + mon_errors, handshakes, outputs);
        if (!timed_out && errors + mon_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule : pwconv_tb

// ==== build.f ====
common/pwconv_pkg.sv
common/pwconv_ctrl_if.sv
mac_chain/mac_stage.sv
mac_chain/mac_chain.sv
design/stream_control.sv
design/output_gather.sv
design/pwconv_top.sv
dv/pwconv_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the pointwise convolution testbench with Verilator and runs it.
# The exit status is zero only when the simulation log holds the pass line.

set -u

cd "$(dirname "$0")" || exit 1

LOG_FILE="sim.log"
OBJ_DIR="obj_dir"

verilator --binary --assert -Mdir "$OBJ_DIR" --top-module pwconv_tb -f build.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ_DIR/Vpwconv_tb" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Everything OK" "$LOG_FILE"; then
    exit 0
fi
echo "Pass line not found in $LOG_FILE"
exit 1
